//--- logic/attn_v_pkg.sv
// package with core sizes, LIF threshold, datapath vector types and control state enum
package attn_v_pkg;

    // block and head sizes
    localparam int SEQ_LEN    = 8;
    localparam int HEAD_DIM   = 4;
    localparam int TIME_STEPS = 4;
    localparam int ATTN_W     = 3;

    // holds SEQ_LEN times the largest score of 7
    localparam int PSUM_W = 8;

    localparam int LIF_THRESHOLD = 12;

    // row-major address i * SEQ_LEN + j
    typedef logic [5:0] attn_addr_t;
    // token index j
    typedef logic [2:0] value_addr_t;

    typedef logic [ATTN_W-1:0] attn_score_t;

    // channel c at bits c*TIME_STEPS upward, step t at offset t
    typedef logic [HEAD_DIM*TIME_STEPS-1:0] value_row_t;

    typedef logic [PSUM_W-1:0] psum_t;
    typedef psum_t [TIME_STEPS-1:0] psum_vec_t;

    typedef logic [TIME_STEPS-1:0] spike_vec_t;
    typedef logic [HEAD_DIM*TIME_STEPS-1:0] spike_word_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_FINISH
    } ctrl_state_t;

endpackage

//--- logic/attn_v_ctrl.sv
// control FSM with buffer read sequencing, accumulate and row-end strobes and output row counting
`timescale 1ns/1ps

module attn_v_ctrl (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_attn_empty,
    input  logic                    i_word_valid,
    output attn_v_pkg::attn_addr_t  o_attn_rd_addr,
    output attn_v_pkg::value_addr_t o_value_rd_addr,
    output logic                    o_attn_done,
    output logic                    o_mac_valid,
    output logic                    o_row_last,
    output logic                    o_block_done
);

    attn_v_pkg::ctrl_state_t state;
    attn_v_pkg::ctrl_state_t state_next;
    attn_v_pkg::attn_addr_t  addr_cnt;
    // output row index
    attn_v_pkg::value_addr_t word_cnt;

    logic rd_en;
    logic addr_last;
    logic col_last;
    logic words_done;

    assign rd_en     = (state == attn_v_pkg::ST_READ);
    assign addr_last = (addr_cnt == attn_v_pkg::attn_addr_t'(
                           attn_v_pkg::SEQ_LEN * attn_v_pkg::SEQ_LEN - 1));
    assign col_last  = (o_value_rd_addr == attn_v_pkg::value_addr_t'(attn_v_pkg::SEQ_LEN - 1));

    assign words_done = i_word_valid &&
                        (word_cnt == attn_v_pkg::value_addr_t'(attn_v_pkg::SEQ_LEN - 1));

    // column part of the attention address selects the value row
    assign o_attn_rd_addr  = addr_cnt;
    assign o_value_rd_addr = attn_v_pkg::value_addr_t'(addr_cnt);

    // buffer may refill once the last address is out
    assign o_attn_done = rd_en && addr_last;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state <= attn_v_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            attn_v_pkg::ST_IDLE: begin
                if (!i_attn_empty)
                    state_next = attn_v_pkg::ST_READ;
            end
            attn_v_pkg::ST_READ: begin
                if (addr_last)
                    state_next = attn_v_pkg::ST_FINISH;
            end
            attn_v_pkg::ST_FINISH: begin
                if (words_done)
                    state_next = attn_v_pkg::ST_IDLE;
            end
            default: state_next = attn_v_pkg::ST_IDLE;
        endcase
    end

    // wraps back to 0 after the last address
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            addr_cnt <= '0;
        end else if (rd_en) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // read data lands one cycle after its address
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_mac_valid <= 1'b0;
            o_row_last  <= 1'b0;
        end else begin
            o_mac_valid <= rd_en;
            o_row_last  <= rd_en && col_last;
        end
    end

    // rows 0..6 finish while still reading, so count in every state
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            word_cnt     <= '0;
            o_block_done <= 1'b0;
        end else begin
            o_block_done <= words_done;
            if (words_done)
                word_cnt <= '0;
            else if (i_word_valid)
                word_cnt <= word_cnt + 1'b1;
        end
    end

endmodule

//--- logic/line_mac_array.sv
// per channel and time step score accumulators with a channel drain shift register
`timescale 1ns/1ps

module line_mac_array (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_mac_valid,
    input  logic                    i_row_last,
    input  attn_v_pkg::attn_score_t i_attn_score,
    input  attn_v_pkg::value_row_t  i_value_row,
    output attn_v_pkg::psum_vec_t   o_psum,
    output logic                    o_psum_valid
);

    attn_v_pkg::psum_vec_t acc      [attn_v_pkg::HEAD_DIM];
    attn_v_pkg::psum_vec_t acc_next [attn_v_pkg::HEAD_DIM];
    attn_v_pkg::psum_vec_t drain    [attn_v_pkg::HEAD_DIM];

    // thermometer count of channels still to drain
    logic [attn_v_pkg::HEAD_DIM-1:0] drain_left;

    // score goes in wherever the value spike is set
    always_comb begin
        for (int c = 0; c < attn_v_pkg::HEAD_DIM; c++) begin
            for (int t = 0; t < attn_v_pkg::TIME_STEPS; t++) begin
                if (i_value_row[c*attn_v_pkg::TIME_STEPS + t])
                    acc_next[c][t] = acc[c][t] + attn_v_pkg::psum_t'(i_attn_score);
                else
                    acc_next[c][t] = acc[c][t];
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int c = 0; c < attn_v_pkg::HEAD_DIM; c++)
                acc[c] <= '0;
        end else if (i_mac_valid) begin
            for (int c = 0; c < attn_v_pkg::HEAD_DIM; c++)
                acc[c] <= i_row_last ? '0 : acc_next[c];
        end
    end

    // row end loads the sums including the last entry, otherwise shift toward slot 0
    always_ff @(posedge s_clk) begin
        if (i_mac_valid && i_row_last) begin
            drain <= acc_next;
        end else if (o_psum_valid) begin
            for (int c = 0; c < attn_v_pkg::HEAD_DIM - 1; c++)
                drain[c] <= drain[c+1];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            drain_left <= '0;
        end else if (i_mac_valid && i_row_last) begin
            drain_left <= '1;
        end else begin
            drain_left <= drain_left >> 1;
        end
    end

    assign o_psum       = drain[0];
    assign o_psum_valid = drain_left[0];

endmodule

//--- logic/lif_neuron.sv
// integrate-and-fire neuron over one channel's time steps with a registered spike output
`timescale 1ns/1ps

module lif_neuron (
    input  logic                   s_clk,
    input  logic                   s_rst,
    input  attn_v_pkg::psum_vec_t  i_psum,
    input  logic                   i_psum_valid,
    output attn_v_pkg::spike_vec_t o_spikes,
    output logic                   o_spikes_valid
);

    // peaks at 188 for four steps of 56 and fits PSUM_W
    attn_v_pkg::psum_t      membrane;
    attn_v_pkg::spike_vec_t spikes_next;

    // membrane starts from rest for every channel
    always_comb begin
        membrane    = '0;
        spikes_next = '0;
        for (int t = 0; t < attn_v_pkg::TIME_STEPS; t++) begin
            membrane = membrane + i_psum[t];
            if (membrane >= attn_v_pkg::psum_t'(attn_v_pkg::LIF_THRESHOLD)) begin
                spikes_next[t] = 1'b1;
                // soft reset so the residual carries to the next step
                membrane = membrane - attn_v_pkg::psum_t'(attn_v_pkg::LIF_THRESHOLD);
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_psum_valid)
            o_spikes <= spikes_next;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_spikes_valid <= 1'b0;
        end else begin
            o_spikes_valid <= i_psum_valid;
        end
    end

endmodule

//--- logic/spike_packer.sv
// packer that collects HEAD_DIM channel spike vectors into one output word per row
`timescale 1ns/1ps

module spike_packer (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  attn_v_pkg::spike_vec_t  i_spikes,
    input  logic                    i_spikes_valid,
    output attn_v_pkg::spike_word_t o_word,
    output logic                    o_word_valid
);

    logic [$clog2(attn_v_pkg::HEAD_DIM)-1:0] ch_cnt;
    attn_v_pkg::spike_word_t word_buf;
    attn_v_pkg::spike_word_t word_next;
    logic ch_last;

    assign ch_last = (ch_cnt == attn_v_pkg::HEAD_DIM - 1);

    // same layout as a value row
    always_comb begin
        word_next = word_buf;
        word_next[ch_cnt*attn_v_pkg::TIME_STEPS +: attn_v_pkg::TIME_STEPS] = i_spikes;
    end

    always_ff @(posedge s_clk) begin
        if (i_spikes_valid) begin
            word_buf <= word_next;
            if (ch_last)
                o_word <= word_next;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            ch_cnt       <= '0;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= i_spikes_valid && ch_last;
            // natural wrap restarts at channel 0
            if (i_spikes_valid)
                ch_cnt <= ch_cnt + 1'b1;
        end
    end

endmodule

//--- logic/attn_v_top.sv
// top level wiring the control FSM, MAC array, LIF neuron and spike packer
`timescale 1ns/1ps

module attn_v_top (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_attn_empty,
    input  attn_v_pkg::attn_score_t i_attn_data,
    input  attn_v_pkg::value_row_t  i_value_data,
    output attn_v_pkg::attn_addr_t  o_attn_rd_addr,
    output attn_v_pkg::value_addr_t o_value_rd_addr,
    output logic                    o_attn_done,
    output attn_v_pkg::spike_word_t o_spike_data,
    output logic                    o_spike_valid,
    output logic                    o_block_done
);

    logic                   mac_valid;
    logic                   row_last;
    attn_v_pkg::psum_vec_t  psum;
    logic                   psum_valid;
    attn_v_pkg::spike_vec_t spikes;
    logic                   spikes_valid;

    attn_v_ctrl u_ctrl (
        .s_clk           (s_clk),
        .s_rst           (s_rst),
        .i_attn_empty    (i_attn_empty),
        .i_word_valid    (o_spike_valid),
        .o_attn_rd_addr  (o_attn_rd_addr),
        .o_value_rd_addr (o_value_rd_addr),
        .o_attn_done     (o_attn_done),
        .o_mac_valid     (mac_valid),
        .o_row_last      (row_last),
        .o_block_done    (o_block_done)
    );

    // buffer data arrives aligned with mac_valid
    line_mac_array u_mac (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_mac_valid  (mac_valid),
        .i_row_last   (row_last),
        .i_attn_score (i_attn_data),
        .i_value_row  (i_value_data),
        .o_psum       (psum),
        .o_psum_valid (psum_valid)
    );

    lif_neuron u_lif (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_psum         (psum),
        .i_psum_valid   (psum_valid),
        .o_spikes       (spikes),
        .o_spikes_valid (spikes_valid)
    );

    spike_packer u_packer (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_spikes       (spikes),
        .i_spikes_valid (spikes_valid),
        .o_word         (o_spike_data),
        .o_word_valid   (o_spike_valid)
    );

endmodule

//--- tb/attn_v_assertions.sv
// bound checker for one-cycle pulses and strobes that must never meet a blocking condition
`timescale 1ns/1ps

module attn_v_assertions (
    input logic s_clk,
    input logic s_rst,
    input logic i_pulse,
    input logic i_strobe,
    input logic i_forbidden
);

    int fail_cnt = 0;

    // done pulses and the row-end strobe
    assert property (@(posedge s_clk) disable iff (s_rst) i_pulse |=> !i_pulse)
        else begin
            $error("pulse held for more than one cycle");
            fail_cnt++;
        end

    // mac_valid in idle, block done while accumulating, or a row reload during a drain
    assert property (@(posedge s_clk) disable iff (s_rst) i_strobe |-> !i_forbidden)
        else begin
            $error("strobe raised while its blocking condition holds");
            fail_cnt++;
        end

endmodule

//--- tb/attn_v_tb.sv
// testbench with clock, reset, buffer read models, golden data, two-block stimulus and checks
`timescale 1ns/1ps

module attn_v_tb;

    localparam int TIMEOUT = 100;

    logic                    s_clk;
    logic                    s_rst;
    logic                    i_attn_empty;
    attn_v_pkg::attn_score_t i_attn_data;
    attn_v_pkg::value_row_t  i_value_data;
    attn_v_pkg::attn_addr_t  o_attn_rd_addr;
    attn_v_pkg::value_addr_t o_value_rd_addr;
    logic                    o_attn_done;
    attn_v_pkg::spike_word_t o_spike_data;
    logic                    o_spike_valid;
    logic                    o_block_done;

    // attention rows at 0, value rows at 8, expected words at 16
    logic [31:0]             golden [24];
    attn_v_pkg::attn_addr_t  attn_addr_q;
    attn_v_pkg::value_addr_t value_addr_q;
    integer                  seed;

    attn_v_top UUT (.*);

    bind attn_v_ctrl attn_v_assertions u_ctrl_sva (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_pulse     (o_block_done),
        .i_strobe    (o_mac_valid),
        .i_forbidden (state == attn_v_pkg::ST_IDLE)
    );

    bind attn_v_ctrl attn_v_assertions u_done_sva (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_pulse     (o_attn_done),
        .i_strobe    (o_block_done),
        .i_forbidden (o_mac_valid)
    );

    bind line_mac_array attn_v_assertions u_mac_sva (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_pulse     (i_mac_valid && i_row_last),
        .i_strobe    (i_mac_valid && i_row_last),
        .i_forbidden (o_psum_valid)
    );

    initial begin
        s_clk = 1'b0;
        forever #2 s_clk = ~s_clk;
    end

    // buffer read ports return data one cycle after the address
    always @(negedge s_clk) begin
        i_attn_data  = golden[attn_addr_q[5:3]][{attn_addr_q[2:0], 2'b00} +: 3];
        i_value_data = golden[8 + value_addr_q][15:0];
        attn_addr_q  = o_attn_rd_addr;
        value_addr_q = o_value_rd_addr;
    end

    function automatic int assert_failures();
        return UUT.u_ctrl.u_ctrl_sva.fail_cnt + UUT.u_ctrl.u_done_sva.fail_cnt
               + UUT.u_mac.u_mac_sva.fail_cnt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // a bound assertion failure ends the run at the next falling edge
    always @(negedge s_clk) begin
        if (assert_failures() != 0) begin
            $display("A bound assertion failed before %0t", $time);
            stop_failed();
        end
    end

    task automatic run_block(input int blk);
        int gap;
        int addr;
        int words;
        int idle;
        gap   = 2 + ($random(seed) & 15);
        addr  = 0;
        words = 0;
        idle  = 0;
        // core stays quiet while the buffers are empty
        repeat (gap) begin
            @(negedge s_clk);
            check_value("o_attn_rd_addr", o_attn_rd_addr, 0);
            check_value("o_attn_done", o_attn_done, 0);
            check_value("o_spike_valid", o_spike_valid, 0);
            check_value("o_block_done", o_block_done, 0);
        end
        i_attn_empty = 1'b0;
        // address stream and output words overlap since rows 0..6 finish while reading
        do begin
            @(negedge s_clk);
            if (words < 8)
                check_value("o_block_done", o_block_done, 0);
            if (addr < 64) begin
                check_value("o_attn_rd_addr", o_attn_rd_addr, addr);
                check_value("o_value_rd_addr", o_value_rd_addr, addr % 8);
                check_value("o_attn_done", o_attn_done, addr == 63);
                addr++;
            end else begin
                // buffer may refill after the last address
                i_attn_empty = 1'b1;
                check_value("o_attn_done", o_attn_done, 0);
            end
            if (words < 8 && o_spike_valid) begin
                check_value("o_spike_data", o_spike_data, golden[16 + words]);
                words++;
                idle = 0;
            end else begin
                // no further word once the block is complete
                if (words == 8)
                    check_value("o_spike_valid", o_spike_valid, 0);
                idle++;
                if (idle > TIMEOUT) begin
                    $display("Timed out in block %0d after %0d of 8 output words", blk, words);
                    stop_failed();
                end
            end
        end while (!o_block_done);
    endtask

    initial begin
        seed         = 32'h349;
        s_rst        = 1'b1;
        i_attn_empty = 1'b1;
        i_attn_data  = '0;
        i_value_data = '0;
        attn_addr_q  = '0;
        value_addr_q = '0;
        $readmemh("tb/attn_v_golden.txt", golden);
        repeat (8) @(negedge s_clk);
        s_rst = 1'b0;
        // same block twice, so accumulators and counters must clear in between
        run_block(1);
        run_block(2);
        @(negedge s_clk);
        if (assert_failures() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "assertion failures were reported");
        end
    end

endmodule

//--- attn_v.f
logic/attn_v_pkg.sv
logic/attn_v_ctrl.sv
logic/line_mac_array.sv
logic/lif_neuron.sv
logic/spike_packer.sv
logic/attn_v_top.sv
tb/attn_v_assertions.sv
tb/attn_v_tb.sv

//--- tb/attn_v_golden.txt
// attention rows A[i] (hex digit j from the right is A[i][j]), then value rows V[j]
// (hex digit c is channel c, bit t is time step t), then the expected output word of each row
11111111
77777777
76543210
01234567
40200503
00006000
22222222
26017035
009D
0691
0495
F291
00A5
02A1
00A5
02E1
0084
AEFF
82E7
42BF
00A9
A080
04A5
A2B7
